//--- include/dmm_defs.svh
`ifndef DMM_DEFS_SVH
`define DMM_DEFS_SVH

// apb register map, one 32 bit word each
`define DMM_ADDR_MODE       8'h00
`define DMM_ADDR_DIRECT     8'h04
`define DMM_ADDR_APERTURE   8'h08
`define DMM_ADDR_PRECHARGE  8'h0C
`define DMM_ADDR_ARM        8'h10
`define DMM_ADDR_AZMUX      8'h14   // lo code 3:0, hi code 7:4
`define DMM_ADDR_STATUS     8'h18   // read only
`define DMM_ADDR_COUNT      8'h1C   // read only

// output mode codes, any other code drives pins low
`define DMM_MODE_DIRECT     3'd0
`define DMM_MODE_LO         3'd1
`define DMM_MODE_HI         3'd2
`define DMM_MODE_AZ         3'd4

`define DMM_STATUS_MAGIC    8'haa

// board pin vector layout
`define DMM_PIN_LEDS_LO            0
`define DMM_PIN_LEDS_HI            3
`define DMM_PIN_MONITOR_LO         4
`define DMM_PIN_MONITOR_HI         11
`define DMM_PIN_SPI_INTERRUPT_CTL  12
`define DMM_PIN_MEAS_COMPLETE      13
`define DMM_PIN_SIG_PC_SW_LO       14
`define DMM_PIN_SIG_PC_SW_HI       15
`define DMM_PIN_AZMUX_LO           16
`define DMM_PIN_AZMUX_HI           19
`define DMM_PIN_ADC_CMPR_LATCH     20
`define DMM_PIN_ADC_REFMUX_LO      21
`define DMM_PIN_ADC_REFMUX_HI      24

`endif

//--- logic/dmm_pkg.sv
package dmm_pkg;

  //////////////////////////////
  // bus and register widths

  typedef logic [31:0] reg_word_t;     // apb data, full register
  typedef logic [7:0]  apb_addr_t;     // byte address
  typedef logic [2:0]  mode_sel_t;     // pin mode / alternate function
  typedef logic [23:0] precharge_t;    // precharge length in clks

  //////////////////////////////
  // sequencer and pins

  typedef logic [3:0]  azmux_t;        // analog mux code
  typedef logic [2:0]  az_status_t;    // bit 0 phase hi, bit 1 running
  typedef logic [15:0] sample_count_t; // completed samples
  typedef logic [24:0] pin_vec_t;      // packed board pins

  // auto-zero sequencer states
  typedef enum logic [2:0] {
    IDLE,
    PC_LO,       // precharge on the zero reference
    SAMPLE_LO,   // adc aperture on the zero reference
    PC_HI,       // precharge on the signal
    SAMPLE_HI    // adc aperture on the signal
  } az_state_t;

endpackage

//--- logic/dmm_regs.sv
`timescale 1ns/1ps
`include "dmm_defs.svh"

module dmm_regs (
  input  logic                    clk,
  input  logic                    arst_n_i,
  // apb slave, zero wait states
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  dmm_pkg::apb_addr_t      paddr_i,
  input  dmm_pkg::reg_word_t      pwdata_i,
  output dmm_pkg::reg_word_t      prdata_o,
  // readable inputs
  input  logic [3:0]              hw_flags_i,
  input  dmm_pkg::az_status_t     az_status_i,
  input  dmm_pkg::sample_count_t  sample_count_i,
  // configuration out
  output dmm_pkg::mode_sel_t      mode_o,
  output dmm_pkg::reg_word_t      direct_o,
  output dmm_pkg::reg_word_t      aperture_o,
  output dmm_pkg::precharge_t     precharge_o,
  output dmm_pkg::azmux_t         azmux_lo_o,
  output dmm_pkg::azmux_t         azmux_hi_o,
  output logic                    arm_o
);
  import dmm_pkg::*;

  logic      wr_en;        // access phase of a write
  reg_word_t status_word;

  assign wr_en = psel_i && penable_i && pwrite_i;

  // zeros, flags 14:11, sequencer 10:8, magic 7:0
  assign status_word = {17'b0, hw_flags_i, az_status_i, `DMM_STATUS_MAGIC};

  //////////////////////////////
  // write side

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mode_o      <= '0;   // direct mode, pins follow direct word
      direct_o    <= '0;
      aperture_o  <= '0;
      precharge_o <= '0;
      azmux_lo_o  <= '0;
      azmux_hi_o  <= '0;
      arm_o       <= 1'b0; // sequencer parked
    end else if (wr_en) begin
      case (paddr_i)
        `DMM_ADDR_MODE:      mode_o      <= pwdata_i[2:0];
        `DMM_ADDR_DIRECT:    direct_o    <= pwdata_i;
        `DMM_ADDR_APERTURE:  aperture_o  <= pwdata_i;
        `DMM_ADDR_PRECHARGE: precharge_o <= pwdata_i[23:0];
        `DMM_ADDR_ARM:       arm_o       <= pwdata_i[0];
        `DMM_ADDR_AZMUX: begin
          azmux_lo_o <= pwdata_i[3:0];
          azmux_hi_o <= pwdata_i[7:4];
        end
        default: ;  // unmapped, and status/count are read only
      endcase
    end
  end

  //////////////////////////////
  // read side, decoded straight from paddr

  always_comb begin
    case (paddr_i)
      `DMM_ADDR_MODE:      prdata_o = {29'b0, mode_o};
      `DMM_ADDR_DIRECT:    prdata_o = direct_o;
      `DMM_ADDR_APERTURE:  prdata_o = aperture_o;
      `DMM_ADDR_PRECHARGE: prdata_o = {8'b0, precharge_o};
      `DMM_ADDR_ARM:       prdata_o = {31'b0, arm_o};
      `DMM_ADDR_AZMUX:     prdata_o = {24'b0, azmux_hi_o, azmux_lo_o};
      `DMM_ADDR_STATUS:    prdata_o = status_word;
      `DMM_ADDR_COUNT:     prdata_o = {16'b0, sample_count_i};
      default:             prdata_o = '0;  // unmapped
    endcase
  end

endmodule

//--- logic/sample_acquisition_az.sv
`timescale 1ns/1ps

module sample_acquisition_az (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  logic                    arm_i,
  input  dmm_pkg::precharge_t     precharge_i,
  input  dmm_pkg::azmux_t         azmux_lo_i,   // zero reference code
  input  dmm_pkg::azmux_t         azmux_hi_i,   // signal input code
  input  logic                    adc_valid_i,  // fan-in from adc
  output logic                    adc_trig_o,
  output logic                    sw_pc_o,
  output dmm_pkg::azmux_t         azmux_o,
  output logic                    led_o,
  output logic                    meas_complete_o,
  output dmm_pkg::az_status_t     status_o,
  output dmm_pkg::sample_count_t  sample_count_o
);
  import dmm_pkg::*;

  az_state_t  state_q;
  precharge_t pc_cnt_q;   // precharge cycles left
  logic       sampling;   // waiting on the adc, either phase
  logic       phase_hi;
  logic       running;

  assign sampling = (state_q == SAMPLE_LO) || (state_q == SAMPLE_HI);
  assign phase_hi = (state_q == PC_HI) || (state_q == SAMPLE_HI);
  assign running  = (state_q != IDLE);

  //////////////////////////////
  // state machine

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q         <= IDLE;
      pc_cnt_q        <= '0;
      adc_trig_o      <= 1'b0;
      meas_complete_o <= 1'b0;
      sample_count_o  <= '0;
    end else begin
      adc_trig_o      <= 1'b0;  // single cycle pulses
      meas_complete_o <= 1'b0;

      // every finished aperture counts, lo and hi alike
      if (sampling && adc_valid_i) begin
        sample_count_o <= sample_count_o + 1'b1;
      end
      if ((state_q == SAMPLE_HI) && adc_valid_i) begin
        meas_complete_o <= 1'b1;   // full lo/hi pair done
      end

      if (!arm_i) begin
        state_q <= IDLE;            // disarm wins from any state
      end else begin
        case (state_q)
          IDLE: begin
            state_q  <= PC_LO;
            pc_cnt_q <= precharge_i;
          end
          PC_LO, PC_HI: begin
            if (pc_cnt_q < 24'd2) begin
              // precharge done, fire the adc on entry
              state_q    <= (state_q == PC_LO) ? SAMPLE_LO : SAMPLE_HI;
              adc_trig_o <= 1'b1;
            end else begin
              pc_cnt_q <= pc_cnt_q - 1'b1;
            end
          end
          SAMPLE_LO: begin
            if (adc_valid_i) begin
              state_q  <= PC_HI;
              pc_cnt_q <= precharge_i;
            end
          end
          SAMPLE_HI: begin
            if (adc_valid_i) begin
              state_q  <= PC_LO;     // still armed, go around again
              pc_cnt_q <= precharge_i;
            end
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  //////////////////////////////
  // outputs decoded from state

  always_comb begin
    case (state_q)
      PC_LO, SAMPLE_LO: azmux_o = azmux_lo_i;
      PC_HI, SAMPLE_HI: azmux_o = azmux_hi_i;
      default:          azmux_o = '0;   // idle, mux parked
    endcase
  end

  assign sw_pc_o  = (state_q == PC_LO) || (state_q == PC_HI);  // precharge switch closed
  assign led_o    = phase_hi;
  assign status_o = {1'b0, running, phase_hi};   // bit 2 reserved

endmodule

//--- logic/adc_aperture.sv
`timescale 1ns/1ps

module adc_aperture (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               trig_i,
  input  dmm_pkg::reg_word_t aperture_i,  // in clks
  output logic               valid_o,
  output logic [3:0]         monitor_o    // scope debug
);
  import dmm_pkg::*;

  reg_word_t cnt_q;
  reg_word_t aperture_eff;  // zero aperture behaves as one
  logic      busy_q;

  assign aperture_eff = (aperture_i == '0) ? 32'd1 : aperture_i;

  // trig in cycle T loads the count, valid lands in T + aperture
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (!busy_q) begin
      if (trig_i) begin
        busy_q <= 1'b1;
        cnt_q  <= aperture_eff;
      end
    end else begin
      cnt_q <= cnt_q - 1'b1;   // triggers ignored while busy
      if (cnt_q == 32'd1) begin
        busy_q <= 1'b0;        // last cycle of the aperture
      end
    end
  end

  assign valid_o   = busy_q && (cnt_q == 32'd1);
  assign monitor_o = {busy_q, cnt_q[2:0]};

endmodule

//--- logic/pin_output_stage.sv
`timescale 1ns/1ps
`include "dmm_defs.svh"

module pin_output_stage (
  input  logic               clk,
  input  logic               arst_n_i,
  input  dmm_pkg::mode_sel_t mode_i,
  input  dmm_pkg::reg_word_t direct_i,
  // auto-zero sources
  input  logic               az_sw_pc_i,
  input  dmm_pkg::azmux_t    az_azmux_i,
  input  logic               az_led_i,
  input  logic               az_meas_complete_i,
  input  logic               adc_trig_i,
  input  logic [3:0]         adc_monitor_i,
  // board pins
  output logic [3:0]         leds_o,
  output logic [7:0]         monitor_o,
  output logic               spi_interrupt_ctl_o,
  output logic               meas_complete_o,
  output logic [1:0]         sig_pc_sw_o,
  output logic [3:0]         azmux_o,
  output logic               adc_cmpr_latch_o,
  output logic [3:0]         adc_refmux_o
);
  import dmm_pkg::*;

  pin_vec_t pins_d;
  pin_vec_t pins_q;

  //////////////////////////////
  // mode select

  always_comb begin
    pins_d = '0;   // unused codes leave every pin low
    case (mode_i)
      `DMM_MODE_DIRECT: pins_d = direct_i[$bits(pin_vec_t)-1:0];
      `DMM_MODE_LO:     pins_d = '0;
      `DMM_MODE_HI:     pins_d = '1;
      `DMM_MODE_AZ: begin
        pins_d[`DMM_PIN_LEDS_LO]                        = az_led_i;
        pins_d[`DMM_PIN_MONITOR_LO +: 4]                = adc_monitor_i;
        pins_d[`DMM_PIN_MONITOR_LO + 4]                 = adc_trig_i;
        pins_d[`DMM_PIN_SPI_INTERRUPT_CTL]              = az_meas_complete_i; // irq to mcu
        pins_d[`DMM_PIN_MEAS_COMPLETE]                  = az_meas_complete_i;
        pins_d[`DMM_PIN_SIG_PC_SW_LO]                   = az_sw_pc_i;
        pins_d[`DMM_PIN_AZMUX_HI:`DMM_PIN_AZMUX_LO]     = az_azmux_i;
      end
      default: pins_d = '0;
    endcase
  end

  // one clk of latency on every pin
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pins_q <= '0;
    end else begin
      pins_q <= pins_d;
    end
  end

  //////////////////////////////
  // unpack to pins

  assign leds_o              = pins_q[`DMM_PIN_LEDS_HI:`DMM_PIN_LEDS_LO];
  assign monitor_o           = pins_q[`DMM_PIN_MONITOR_HI:`DMM_PIN_MONITOR_LO];
  assign spi_interrupt_ctl_o = pins_q[`DMM_PIN_SPI_INTERRUPT_CTL];
  assign meas_complete_o     = pins_q[`DMM_PIN_MEAS_COMPLETE];
  assign sig_pc_sw_o         = pins_q[`DMM_PIN_SIG_PC_SW_HI:`DMM_PIN_SIG_PC_SW_LO];
  assign azmux_o             = pins_q[`DMM_PIN_AZMUX_HI:`DMM_PIN_AZMUX_LO];
  assign adc_cmpr_latch_o    = pins_q[`DMM_PIN_ADC_CMPR_LATCH];
  assign adc_refmux_o        = pins_q[`DMM_PIN_ADC_REFMUX_HI:`DMM_PIN_ADC_REFMUX_LO];

endmodule

//--- logic/dmm_top.sv
`timescale 1ns/1ps

module dmm_top (
  input  logic               clk,
  input  logic               arst_n_i,
  // apb from the mcu bridge
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  dmm_pkg::apb_addr_t paddr_i,
  input  dmm_pkg::reg_word_t pwdata_i,
  output dmm_pkg::reg_word_t prdata_o,
  input  logic [3:0]         hw_flags_i,
  // board pins
  output logic [3:0]         leds_o,
  output logic [7:0]         monitor_o,
  output logic               spi_interrupt_ctl_o,
  output logic               meas_complete_o,
  output logic [1:0]         sig_pc_sw_o,
  output logic [3:0]         azmux_o,       // u410
  output logic               adc_cmpr_latch_o,
  output logic [3:0]         adc_refmux_o   // u902 ref current mux
);
  import dmm_pkg::*;

  // register block outputs
  mode_sel_t     reg_mode;
  reg_word_t     reg_direct;
  reg_word_t     reg_aperture;
  precharge_t    reg_precharge;
  azmux_t        reg_azmux_lo;
  azmux_t        reg_azmux_hi;
  logic          reg_arm;

  // sequencer and adc
  logic          az_sw_pc;
  azmux_t        az_azmux;
  logic          az_led;
  logic          az_meas_complete;
  az_status_t    az_status;
  sample_count_t az_sample_count;
  logic          adc_trig;
  logic          adc_valid;
  logic [3:0]    adc_monitor;

  dmm_regs dmm_regs (
    .clk(clk), .arst_n_i(arst_n_i),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
    .hw_flags_i(hw_flags_i), .az_status_i(az_status), .sample_count_i(az_sample_count),
    .mode_o(reg_mode), .direct_o(reg_direct), .aperture_o(reg_aperture),
    .precharge_o(reg_precharge), .azmux_lo_o(reg_azmux_lo), .azmux_hi_o(reg_azmux_hi),
    .arm_o(reg_arm)
  );

  sample_acquisition_az sample_acquisition_az (
    .clk(clk), .arst_n_i(arst_n_i),
    .arm_i(reg_arm), .precharge_i(reg_precharge),
    .azmux_lo_i(reg_azmux_lo), .azmux_hi_i(reg_azmux_hi),
    .adc_valid_i(adc_valid), .adc_trig_o(adc_trig),
    .sw_pc_o(az_sw_pc), .azmux_o(az_azmux), .led_o(az_led),
    .meas_complete_o(az_meas_complete), .status_o(az_status),
    .sample_count_o(az_sample_count)
  );

  adc_aperture adc_aperture (
    .clk(clk), .arst_n_i(arst_n_i),
    .trig_i(adc_trig), .aperture_i(reg_aperture),
    .valid_o(adc_valid), .monitor_o(adc_monitor)
  );

  pin_output_stage pin_output_stage (
    .clk(clk), .arst_n_i(arst_n_i),
    .mode_i(reg_mode), .direct_i(reg_direct),
    .az_sw_pc_i(az_sw_pc), .az_azmux_i(az_azmux), .az_led_i(az_led),
    .az_meas_complete_i(az_meas_complete), .adc_trig_i(adc_trig),
    .adc_monitor_i(adc_monitor),
    .leds_o(leds_o), .monitor_o(monitor_o), .spi_interrupt_ctl_o(spi_interrupt_ctl_o),
    .meas_complete_o(meas_complete_o), .sig_pc_sw_o(sig_pc_sw_o), .azmux_o(azmux_o),
    .adc_cmpr_latch_o(adc_cmpr_latch_o), .adc_refmux_o(adc_refmux_o)
  );

endmodule

//--- verification/dmm_top_tb.sv
`timescale 1ns/1ps

module dmm_top_tb;
  import dmm_pkg::*;

  localparam int PERIOD     = 40;
  localparam int POLL_LIMIT = 200;  // count reads before giving up
  localparam int POLL_COST  = 3;    // clks per apb read
  localparam int MARGIN     = 200;  // clks on top of the stim budget

  logic       clk;
  logic       arst_n;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_addr_t  paddr;
  reg_word_t  pwdata;
  reg_word_t  prdata;
  logic [3:0] hw_flags;

  // board pins
  logic [3:0] leds;
  logic [7:0] monitor;
  logic       spi_int;
  logic       meas_complete;
  logic [1:0] sig_pc_sw;
  logic [3:0] azmux;
  logic       adc_cmpr_latch;
  logic [3:0] adc_refmux;
  pin_vec_t   pins;

  // parsed stimulus, one entry per line
  byte        cmd_q[$];
  string      name_q[$];
  apb_addr_t  addr_q[$];
  reg_word_t  val_q[$];

  int         err_cnt;
  int         test_errs;  // errors in the running test
  int         test_cnt;

  assign pins = {adc_refmux, adc_cmpr_latch, azmux, sig_pc_sw,
                 meas_complete, spi_int, monitor, leds};  // same layout as the pin vector

  dmm_top UUT (
    .clk(clk), .arst_n_i(arst_n),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
    .hw_flags_i(hw_flags),
    .leds_o(leds), .monitor_o(monitor), .spi_interrupt_ctl_o(spi_int),
    .meas_complete_o(meas_complete), .sig_pc_sw_o(sig_pc_sw), .azmux_o(azmux),
    .adc_cmpr_latch_o(adc_cmpr_latch), .adc_refmux_o(adc_refmux)
  );

  always #(PERIOD/2) clk = ~clk;

  //////////////////////////////
  // apb master, driven on falling edges

  task automatic write_reg(input apb_addr_t addr, input reg_word_t data);
    @(negedge clk);
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;  // access, lands on next rising edge
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input apb_addr_t addr, output reg_word_t data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    data = prdata;   // access phase value, paddr settled a cycle ago
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  //////////////////////////////
  // compares

  task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_pins(input string name, input pin_vec_t exp, input pin_vec_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  // keeps reading until the count gets there
  task automatic poll_count(input string name, input apb_addr_t addr, input reg_word_t target);
    reg_word_t cnt;
    int        polls;
    read_reg(addr, cnt);
    polls = 1;
    while (cnt < target && polls < POLL_LIMIT) begin
      read_reg(addr, cnt);
      polls++;
    end
    if (cnt < target) begin
      $display("%s: sample count stuck at %0d after %0d reads, wanted %0d",
               name, cnt, polls, target);
      test_errs++;
    end
  endtask

  //////////////////////////////
  // stimulus file

  task automatic load_stim(output int budget);
    int        fd;
    int        n;
    string     line;
    byte       c;
    string     name;
    apb_addr_t a;
    reg_word_t v;
    budget = MARGIN;
    fd = $fopen("verification/dmm_stim.dat", "r");
    if (fd == 0) begin
      $display("could not open verification/dmm_stim.dat");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 4 || line[0] == "#") continue;  // blank or comment
      n = $sscanf(line, "%c %s %h %h", c, name, a, v);
      if (n != 4) begin
        $display("malformed stimulus line: %s", line);
        err_cnt++;
        continue;
      end
      cmd_q.push_back(c);
      name_q.push_back(name);
      addr_q.push_back(a);
      val_q.push_back(v);
      budget += 4;                             // one transfer or pin settle
      if (c == "D") budget += v;
      if (c == "C") budget += POLL_LIMIT * POLL_COST;
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int i);
    reg_word_t rd;
    test_errs = 0;
    case (cmd_q[i])
      "W": write_reg(addr_q[i], val_q[i]);
      "R": begin
        read_reg(addr_q[i], rd);
        check_word(name_q[i], val_q[i], rd);
      end
      "P": begin
        repeat (2) @(negedge clk);           // register stage plus slack
        check_pins(name_q[i], val_q[i][24:0], pins);
      end
      "F": begin
        @(negedge clk);
        hw_flags = val_q[i][3:0];
      end
      "C": poll_count(name_q[i], addr_q[i], val_q[i]);
      "D": repeat (val_q[i]) @(negedge clk);
      default: begin
        $display("%s: unknown command letter %c", name_q[i], cmd_q[i]);
        test_errs++;
      end
    endcase
    test_cnt++;
    err_cnt += test_errs;
    if (test_errs == 0) $display("%s: ok", name_q[i]);
    else $display("%s: bad", name_q[i]);
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clk);
    $display("watchdog ran out after %0d clocks, the run hung", cycles);
    $display("test failed");
    $finish;
  endtask

  //////////////////////////////
  // main sequence

  initial begin
    int budget;
    clk       = 1'b0;
    arst_n    = 1'b0;  // reset from time 0
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    hw_flags  = '0;
    err_cnt   = 0;
    test_errs = 0;
    test_cnt  = 0;
    load_stim(budget);
    if (cmd_q.size() == 0) begin
      $display("no stimulus was loaded, nothing to run");
      $display("test failed");
      $finish;
    end else begin
      fork
        watchdog(budget);
      join_none
      repeat (2) @(negedge clk);
      arst_n = 1'b1;   // released after 2 clks
      foreach (cmd_q[i]) run_test(i);
      $display("tests %0d, errors %0d", test_cnt, err_cnt);
      if (err_cnt == 0) $display("test passed");
      else $display("test failed");
      $finish;
    end
  end

endmodule

//--- verification/dmm_stim.dat
# columns: cmd name addr value, addr and value in hex
# W write, R read and compare, P pins after 2 clks, F hw flags, C count at least, D idle clks
P reset_pins      00 00000000
R reset_status    18 000000aa
R reset_count     1c 00000000
W mode_wr         00 fffffff5
R mode_rd         00 00000005
W direct_wr       04 fedcba98
R direct_rd       04 fedcba98
W aperture_wr     08 00000003
R aperture_rd     08 00000003
W precharge_wr    0c a500000a
R precharge_rd    0c 0000000a
W azmux_wr        14 ffffff5a
R azmux_rd        14 0000005a
W unmapped_wr     20 12345678
R unmapped_rd     20 00000000
W mode_direct     00 00000000
P pins_direct     00 00dcba98
W mode_lo         00 00000001
P pins_lo         00 00000000
W mode_hi         00 00000002
P pins_hi         00 01ffffff
W mode_code6      00 00000006
P pins_code6      00 00000000
F flags_set       00 0000000b
R flags_status    18 000058aa
W mode_az         00 00000004
W arm_set         10 00000001
R arm_rd          10 00000001
C count_six       1c 00000006
W arm_clear       10 00000000
D settle          00 00000014
R count_even      1c 00000006
R count_stable    1c 00000006
R status_idle     18 000058aa
P pins_idle       00 00000000
W precharge_long  0c 00001000
W arm_long        10 00000001
R status_pc_lo    18 00005aaa
W arm_off         10 00000000

//--- all.f
+incdir+include
logic/dmm_pkg.sv
logic/dmm_regs.sv
logic/sample_acquisition_az.sv
logic/adc_aperture.sv
logic/pin_output_stage.sv
logic/dmm_top.sv
verification/dmm_top_tb.sv
